// File: dmm_pkg.sv
// shared types for the acquisition core of the multimeter front end
// one package only, no module code here
// count fields are plain binary, a zero clk_fix, clk_var or aperture is not
// a legal setting while the converter runs

package dmm_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // register interface

  localparam int REG_ADDR_W = 4;
  localparam int REG_DATA_W = 32;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_DATA_W-1:0] reg_data_t;

  localparam reg_addr_t ADDR_MODE      = 4'd0;   // 2 bit mode select
  localparam reg_addr_t ADDR_DIRECT    = 4'd1;   // low 24 bits map onto the pin bus
  localparam reg_addr_t ADDR_PRECHARGE = 4'd2;   // precharge clocks per entry
  localparam reg_addr_t ADDR_SEQ_N     = 4'd3;   // entries minus one
  localparam reg_addr_t ADDR_SEQ0      = 4'd4;
  localparam reg_addr_t ADDR_SEQ1      = 4'd5;
  localparam reg_addr_t ADDR_SEQ2      = 4'd6;
  localparam reg_addr_t ADDR_SEQ3      = 4'd7;
  localparam reg_addr_t ADDR_APERTURE  = 4'd8;   // in modulation cycles
  localparam reg_addr_t ADDR_CLK_FIX   = 4'd9;   // reset phase length
  localparam reg_addr_t ADDR_CLK_VAR   = 4'd10;  // reference phase length

  ////////////////////////////////////////////////////////////////////////////
  // widths with a meaning

  localparam int SEQ_MAX = 4;

  typedef logic [1:0]  seq_idx_t;
  typedef logic [23:0] clk_count_t;    // clock counts and settings
  typedef logic [15:0] cycle_count_t;  // modulation cycle counts
  typedef logic [3:0]  azmux_t;
  typedef logic [1:0]  pc_sw_t;        // precharge switches
  typedef logic [3:0]  refmux_t;
  typedef logic [3:0]  leds_t;
  typedef logic [7:0]  monitor_t;

  // refmux bit order follows the switch ic pinout
  localparam int REFMUX_POS   = 0;
  localparam int REFMUX_NEG   = 1;
  localparam int REFMUX_SIG   = 2;
  localparam int REFMUX_RESET = 3;

  typedef enum logic [1:0] {
    MODE_DIRECT = 2'd0,  // pins follow the direct register
    MODE_LO     = 2'd1,  // all pins low, default after reset
    MODE_ACQ    = 2'd2   // sequencer plus adc
  } mode_e;

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_PRECHARGE, SEQ_CONVERT, SEQ_COMPLETE} seq_state_e;
  typedef enum logic [1:0] {ADC_IDLE, ADC_RESET, ADC_VAR} adc_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // structs

  typedef struct packed {
    azmux_t azmux;
    pc_sw_t pc_sw;
  } seq_entry_t;

  // msb first, same packing as the direct register
  typedef struct packed {
    logic     meas_complete;
    logic     cmpr_latch;
    refmux_t  refmux;
    azmux_t   azmux;
    pc_sw_t   pc_sw;
    monitor_t monitor;
    leds_t    leds;
  } pin_bus_t;

  typedef struct packed {
    mode_e                     mode;
    pin_bus_t                  direct;
    clk_count_t                precharge;
    seq_idx_t                  seq_n;
    seq_entry_t [SEQ_MAX-1:0]  seq;
    cycle_count_t              aperture;
    clk_count_t                clk_fix;
    clk_count_t                clk_var;
  } cfg_t;

  typedef struct packed {
    seq_idx_t     seq_idx;
    cycle_count_t count_pos;
    cycle_count_t count_neg;
  } adc_result_t;

endpackage

// File: dmm_regs.sv
// configuration register bank, one write per strobe cycle
// wide data is truncated to each field, unknown addresses are dropped
// no readback path

`timescale 1ns/1ns

module dmm_regs (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              reg_wr_i,
  input  dmm_pkg::reg_addr_t reg_addr_i,
  input  dmm_pkg::reg_data_t reg_data_i,
  output dmm_pkg::cfg_t     cfg_o
);
  import dmm_pkg::*;

  cfg_t cfg_q;

  assign cfg_o = cfg_q;  // read live by every stage

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cfg_q.mode      <= MODE_LO;      // pins parked low until software sets a mode
      cfg_q.direct    <= '0;
      cfg_q.precharge <= '0;
      cfg_q.seq_n     <= '0;           // one entry
      cfg_q.seq       <= '0;
      cfg_q.aperture  <= '0;
      cfg_q.clk_fix   <= '0;
      cfg_q.clk_var   <= clk_count_t'(1);
    end else if (reg_wr_i) begin
      case (reg_addr_i)
        ADDR_MODE: begin
          cfg_q.mode <= mode_e'(reg_data_i[1:0]);
        end
        ADDR_DIRECT: begin
          cfg_q.direct <= pin_bus_t'(reg_data_i[23:0]);  // top byte ignored
        end
        ADDR_PRECHARGE: begin
          cfg_q.precharge <= reg_data_i[23:0];
        end
        ADDR_SEQ_N: begin
          cfg_q.seq_n <= reg_data_i[1:0];
        end
        // entries, azmux in [5:2], pc_sw in [1:0]
        ADDR_SEQ0: begin
          cfg_q.seq[0] <= seq_entry_t'(reg_data_i[5:0]);
        end
        ADDR_SEQ1: begin
          cfg_q.seq[1] <= seq_entry_t'(reg_data_i[5:0]);
        end
        ADDR_SEQ2: begin
          cfg_q.seq[2] <= seq_entry_t'(reg_data_i[5:0]);
        end
        ADDR_SEQ3: begin
          cfg_q.seq[3] <= seq_entry_t'(reg_data_i[5:0]);
        end
        ADDR_APERTURE: begin
          cfg_q.aperture <= reg_data_i[15:0];
        end
        ADDR_CLK_FIX: begin
          cfg_q.clk_fix <= reg_data_i[23:0];
        end
        ADDR_CLK_VAR: begin
          cfg_q.clk_var <= reg_data_i[23:0];
        end
        default: begin
          // unmapped, no effect
        end
      endcase
    end
  end

endmodule

// File: seq_ctrl.sv
// sequence controller, steps azmux and precharge through seq_n+1 entries
// one sample in flight, next adc start only after done
// a sample already started completes even when arm_i drops
// result_o is held until the next completion, no back-pressure

`timescale 1ns/1ns

module seq_ctrl (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 arm_i,
  input  dmm_pkg::cfg_t        cfg_i,
  input  logic                 adc_done_i,
  input  dmm_pkg::adc_result_t adc_counts_i,  // seq_idx field not used
  output logic                 adc_start_o,
  output dmm_pkg::azmux_t      azmux_o,
  output dmm_pkg::pc_sw_t      pc_sw_o,
  output logic                 meas_complete_o,
  output dmm_pkg::adc_result_t result_o,
  output dmm_pkg::leds_t       leds_o
);
  import dmm_pkg::*;

  seq_state_e state_q;
  seq_idx_t   idx_q;      // entry being sampled
  clk_count_t pc_cnt_q;   // precharge clocks so far
  seq_idx_t   load_idx;   // entry to load on the next start of an entry
  seq_entry_t load_entry;

  // entry 0 from idle, else step and wrap after seq_n
  always_comb begin
    if (state_q == SEQ_IDLE) begin
      load_idx = '0;
    end else if (idx_q == cfg_i.seq_n) begin
      load_idx = '0;
    end else begin
      load_idx = idx_q + seq_idx_t'(1);
    end
    load_entry = cfg_i.seq[load_idx];
  end

  ////////////////////////////////////////////////////////////////////////////
  // fsm

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q         <= SEQ_IDLE;
      idx_q           <= '0;
      pc_cnt_q        <= '0;
      adc_start_o     <= 1'b0;
      meas_complete_o <= 1'b0;
      azmux_o         <= '0;
      pc_sw_o         <= '0;
    end else begin
      adc_start_o     <= 1'b0;  // strobes, one cycle
      meas_complete_o <= 1'b0;
      case (state_q)
        SEQ_IDLE, SEQ_COMPLETE: begin
          if (arm_i) begin
            idx_q    <= load_idx;
            azmux_o  <= load_entry.azmux;
            pc_sw_o  <= load_entry.pc_sw;
            pc_cnt_q <= '0;
            state_q  <= SEQ_PRECHARGE;
          end else begin
            state_q  <= SEQ_IDLE;
          end
        end
        SEQ_PRECHARGE: begin
          // precharge+1 clocks with the entry switches applied
          if (pc_cnt_q == cfg_i.precharge) begin
            adc_start_o <= 1'b1;
            state_q     <= SEQ_CONVERT;
          end else begin
            pc_cnt_q <= pc_cnt_q + clk_count_t'(1);
          end
        end
        SEQ_CONVERT: begin
          if (adc_done_i) begin
            meas_complete_o <= 1'b1;   // lines up with result_o load
            state_q         <= SEQ_COMPLETE;
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  // result payload, tagged with the entry it belongs to
  always_ff @(posedge clk) begin
    if (state_q == SEQ_CONVERT && adc_done_i) begin
      result_o.seq_idx   <= idx_q;
      result_o.count_pos <= adc_counts_i.count_pos;
      result_o.count_neg <= adc_counts_i.count_neg;
    end
  end

  // led3 armed, led2 converting, led1:0 entry
  assign leds_o = {state_q != SEQ_IDLE, state_q == SEQ_CONVERT, idx_q};

endmodule

// File: adc_modulation.sv
// charge-balance modulator, fixed reset phase then a variable reference phase
// start to done is aperture * (clk_fix + clk_var) + 1 clocks
// clk_fix, clk_var and aperture must be non zero, start ignored while busy
// comparator input is taken as synchronous to clk

`timescale 1ns/1ns

module adc_modulation (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 start_i,
  input  dmm_pkg::cfg_t        cfg_i,
  input  logic                 cmpr_i,
  output dmm_pkg::refmux_t     refmux_o,
  output logic                 cmpr_latch_o,
  output logic                 done_o,
  output dmm_pkg::adc_result_t counts_o,
  output dmm_pkg::monitor_t    monitor_o
);
  import dmm_pkg::*;

  adc_state_e   state_q;
  clk_count_t   clk_cnt_q;   // clocks within the current phase
  cycle_count_t cyc_cnt_q;   // modulation cycles done
  cycle_count_t pos_cnt_q;
  cycle_count_t neg_cnt_q;
  logic         cmpr_q;      // comparator at the first clock of the cycle

  logic         fix_end;
  logic         var_end;
  logic         last_cycle;
  cycle_count_t pos_nxt;
  cycle_count_t neg_nxt;

  assign fix_end    = (clk_cnt_q == cfg_i.clk_fix - clk_count_t'(1));
  assign var_end    = (clk_cnt_q == cfg_i.clk_var - clk_count_t'(1));
  assign last_cycle = (cyc_cnt_q == cfg_i.aperture - cycle_count_t'(1));

  // counts including the cycle that ends now
  assign pos_nxt = pos_cnt_q + cycle_count_t'(cmpr_q);
  assign neg_nxt = neg_cnt_q + cycle_count_t'(!cmpr_q);

  ////////////////////////////////////////////////////////////////////////////
  // fsm and counters

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= ADC_IDLE;
      clk_cnt_q <= '0;
      cyc_cnt_q <= '0;
      pos_cnt_q <= '0;
      neg_cnt_q <= '0;
      cmpr_q    <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        ADC_IDLE: begin
          if (start_i) begin
            clk_cnt_q <= '0;
            cyc_cnt_q <= '0;
            pos_cnt_q <= '0;
            neg_cnt_q <= '0;
            state_q   <= ADC_RESET;
          end
        end
        ADC_RESET: begin
          if (clk_cnt_q == '0) cmpr_q <= cmpr_i;  // decides this cycle's reference
          if (fix_end) begin
            clk_cnt_q <= '0;
            state_q   <= ADC_VAR;
          end else begin
            clk_cnt_q <= clk_cnt_q + clk_count_t'(1);
          end
        end
        ADC_VAR: begin
          if (var_end) begin
            pos_cnt_q <= pos_nxt;
            neg_cnt_q <= neg_nxt;
            clk_cnt_q <= '0;
            if (last_cycle) begin
              done_o  <= 1'b1;
              state_q <= ADC_IDLE;
            end else begin
              cyc_cnt_q <= cyc_cnt_q + cycle_count_t'(1);
              state_q   <= ADC_RESET;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + clk_count_t'(1);
          end
        end
        default: state_q <= ADC_IDLE;
      endcase
    end
  end

  // counts, valid with done_o
  always_ff @(posedge clk) begin
    if (state_q == ADC_VAR && var_end && last_cycle) begin
      counts_o.seq_idx   <= '0;   // tagged by the sequencer
      counts_o.count_pos <= pos_nxt;
      counts_o.count_neg <= neg_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // switch drive

  always_comb begin
    refmux_o = '0;
    case (state_q)
      ADC_RESET: refmux_o[REFMUX_RESET] = 1'b1;
      ADC_VAR: begin
        if (cmpr_q) begin
          refmux_o[REFMUX_POS] = 1'b1;  // integrator above zero, pull down
        end else begin
          refmux_o[REFMUX_NEG] = 1'b1;
        end
      end
      default: refmux_o = '0;
    endcase
    refmux_o[REFMUX_SIG] = (state_q != ADC_IDLE);  // signal in for the whole conversion
  end

  assign cmpr_latch_o = (state_q == ADC_IDLE);     // latched while not running

  assign monitor_o = {refmux_o, cmpr_i, cmpr_q, state_q};

endmodule

// File: pin_mux.sv
// board pin mode select, all outputs come straight from flops
// undefined mode codes park the pins low like MODE_LO
// one clock of latency from any source to the pins

`timescale 1ns/1ns

module pin_mux (
  input  logic              clk,
  input  logic              rst_n_i,
  input  dmm_pkg::mode_e    mode_i,
  input  dmm_pkg::pin_bus_t direct_i,
  input  dmm_pkg::pin_bus_t acq_i,
  output dmm_pkg::pin_bus_t pins_o
);
  import dmm_pkg::*;

  pin_bus_t pins_d;

  // three sources, low is the safe fallback
  always_comb begin
    case (mode_i)
      MODE_DIRECT: pins_d = direct_i;   // software drives every pin
      MODE_ACQ:    pins_d = acq_i;      // live sequencer and adc
      MODE_LO:     pins_d = '0;
      default:     pins_d = '0;
    endcase
  end

  // registered so no glitch from the mux reaches the switches
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pins_o <= '0;
    end else begin
      pins_o <= pins_d;
    end
  end

endmodule

// File: dmm_top.sv
// acquisition core top, regs then sequencer then adc then pin mux
// result_o comes from the sequencer and is held, so it is still valid
// when the registered meas_complete_o strobe reaches the pin
// meas_complete_o only pulses in MODE_ACQ

`timescale 1ns/1ns

module dmm_top (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 reg_wr_i,
  input  dmm_pkg::reg_addr_t   reg_addr_i,
  input  dmm_pkg::reg_data_t   reg_data_i,
  input  logic                 arm_i,
  input  logic                 adc_cmpr_p_i,
  output dmm_pkg::leds_t       leds_o,
  output dmm_pkg::monitor_t    monitor_o,
  output dmm_pkg::pc_sw_t      pc_sw_o,
  output dmm_pkg::azmux_t      azmux_o,
  output dmm_pkg::refmux_t     adc_refmux_o,
  output logic                 adc_cmpr_latch_ctl_o,
  output logic                 meas_complete_o,
  output dmm_pkg::adc_result_t result_o
);
  import dmm_pkg::*;

  cfg_t        cfg;
  logic        adc_start;
  logic        adc_done;
  adc_result_t adc_counts;
  azmux_t      seq_azmux;
  pc_sw_t      seq_pc_sw;
  logic        seq_meas_complete;
  leds_t       seq_leds;
  refmux_t     adc_refmux;
  logic        adc_cmpr_latch;
  monitor_t    adc_monitor;
  pin_bus_t    acq_bus;
  pin_bus_t    pins;

  dmm_regs regs_inst (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .reg_wr_i   (reg_wr_i),
    .reg_addr_i (reg_addr_i),
    .reg_data_i (reg_data_i),
    .cfg_o      (cfg)
  );

  seq_ctrl seq_inst (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .arm_i           (arm_i),
    .cfg_i           (cfg),
    .adc_done_i      (adc_done),
    .adc_counts_i    (adc_counts),
    .adc_start_o     (adc_start),
    .azmux_o         (seq_azmux),
    .pc_sw_o         (seq_pc_sw),
    .meas_complete_o (seq_meas_complete),
    .result_o        (result_o),
    .leds_o          (seq_leds)
  );

  adc_modulation adc_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .start_i      (adc_start),
    .cfg_i        (cfg),
    .cmpr_i       (adc_cmpr_p_i),
    .refmux_o     (adc_refmux),
    .cmpr_latch_o (adc_cmpr_latch),
    .done_o       (adc_done),
    .counts_o     (adc_counts),
    .monitor_o    (adc_monitor)
  );

  // live acquisition bus, same packing as the direct register
  assign acq_bus.meas_complete = seq_meas_complete;
  assign acq_bus.cmpr_latch    = adc_cmpr_latch;
  assign acq_bus.refmux        = adc_refmux;
  assign acq_bus.azmux         = seq_azmux;
  assign acq_bus.pc_sw         = seq_pc_sw;
  assign acq_bus.monitor       = adc_monitor;
  assign acq_bus.leds          = seq_leds;

  pin_mux pin_mux_inst (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .mode_i   (cfg.mode),
    .direct_i (cfg.direct),
    .acq_i    (acq_bus),
    .pins_o   (pins)
  );

  // board pins
  assign meas_complete_o      = pins.meas_complete;
  assign adc_cmpr_latch_ctl_o = pins.cmpr_latch;
  assign adc_refmux_o         = pins.refmux;
  assign azmux_o              = pins.azmux;
  assign pc_sw_o              = pins.pc_sw;
  assign monitor_o            = pins.monitor;
  assign leds_o               = pins.leds;

endmodule

// File: tb_dmm_top.sv
// directed testbench for the acquisition core
// the comparator comes from an integrator model driven by the refmux pins
// all inputs change on the falling clock edge
// a watchdog on the clock count ends the run if a DUT response never arrives

`timescale 1ns/1ns

module tb_dmm_top;
  import dmm_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // test constants

  localparam int REF_WEIGHT  = 1000;  // integrator step per clock of a reference
  localparam int RESET_CLKS  = 10;
  localparam int RESET_WATCH = 20;
  localparam int DIRECT_N    = 6;
  localparam int LAT_PC      = 4;
  localparam int LAT_AP      = 6;
  localparam int LAT_FIX     = 2;
  localparam int LAT_VAR     = 3;
  localparam seq_entry_t LAT_ENTRY = 6'h16;  // azmux 5 and pc_sw 2
  localparam int BAL_PC      = 1;
  localparam int BAL_AP      = 20;
  localparam int BAL_FIX     = 2;
  localparam int BAL_VAR     = 3;
  localparam int BAL_RUNS    = 5;
  localparam int SEQ_PC      = 2;
  localparam int SEQ_AP      = 2;
  localparam int SEQ_FIX     = 1;
  localparam int SEQ_VAR     = 2;
  localparam int SEQ_SAMPLES = 6;   // wraps the four entries once
  localparam int SEQ_WIN     = 40;  // several sample lengths

  // rough length of each test in clocks with one clock per write
  localparam int T_RESET  = RESET_CLKS + 1 + RESET_WATCH;
  localparam int T_DIRECT = 2 + DIRECT_N * 2;
  localparam int T_LAT    = 9 + LAT_PC + 3 + LAT_AP * (LAT_FIX + LAT_VAR) + 4;
  localparam int T_BAL    = 5 + BAL_RUNS * (BAL_PC + 8 + BAL_AP * (BAL_FIX + BAL_VAR));
  localparam int T_SEQ    = 5 + SEQ_MAX + SEQ_WIN
                            + SEQ_SAMPLES * (SEQ_PC + 4 + SEQ_AP * (SEQ_FIX + SEQ_VAR));
  localparam int LIMIT    = T_RESET + T_DIRECT + T_LAT + T_BAL + T_SEQ + 100;

  ////////////////////////////////////////////////////////////////////////////
  // dut and clock

  logic        clk = 1'b0;
  logic        rst_n_i;
  logic        reg_wr_i;
  reg_addr_t   reg_addr_i;
  reg_data_t   reg_data_i;
  logic        arm_i;
  logic        adc_cmpr_p_i;
  leds_t       leds_o;
  monitor_t    monitor_o;
  pc_sw_t      pc_sw_o;
  azmux_t      azmux_o;
  refmux_t     adc_refmux_o;
  logic        adc_cmpr_latch_ctl_o;
  logic        meas_complete_o;
  adc_result_t result_o;

  pin_bus_t    pins_seen;  // board pins packed like the direct register
  int          integ;      // integrator model state
  int          sig_w;      // integrator step while the signal switch is on
  logic [31:0] rng;
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;
  int          cycles;
  string       cur_test;

  dmm_top dmm_top_inst (
    .clk                  (clk),
    .rst_n_i              (rst_n_i),
    .reg_wr_i             (reg_wr_i),
    .reg_addr_i           (reg_addr_i),
    .reg_data_i           (reg_data_i),
    .arm_i                (arm_i),
    .adc_cmpr_p_i         (adc_cmpr_p_i),
    .leds_o               (leds_o),
    .monitor_o            (monitor_o),
    .pc_sw_o              (pc_sw_o),
    .azmux_o              (azmux_o),
    .adc_refmux_o         (adc_refmux_o),
    .adc_cmpr_latch_ctl_o (adc_cmpr_latch_ctl_o),
    .meas_complete_o      (meas_complete_o),
    .result_o             (result_o)
  );

  assign pins_seen = {meas_complete_o, adc_cmpr_latch_ctl_o, adc_refmux_o, azmux_o,
                      pc_sw_o, monitor_o, leds_o};

  initial begin
    forever #5 clk = ~clk;  // 10 ns period
  end

  // watchdog ends the run once the limit over every test is reached
  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not end within %0d clock cycles", LIMIT);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // next falling edge, integrate what the refmux pins show, then drive the comparator
  task automatic step();
    @(negedge clk);
    if (adc_refmux_o[REFMUX_SIG]) integ = integ + sig_w;
    if (adc_refmux_o[REFMUX_POS]) integ = integ - REF_WEIGHT;  // pos reference pulls down
    if (adc_refmux_o[REFMUX_NEG]) integ = integ + REF_WEIGHT;
    adc_cmpr_p_i = (integ > 0);
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    reg_wr_i   = 1'b1;
    reg_addr_i = addr;
    reg_data_i = data;
    step();               // taken on the rising edge in between
    reg_wr_i   = 1'b0;
  endtask

  task automatic setup_conv(input int pc, input int seq_n, input int ap, input int fix,
                            input int var_c);
    write_reg(ADDR_PRECHARGE, reg_data_t'(pc));
    write_reg(ADDR_SEQ_N, reg_data_t'(seq_n));
    write_reg(ADDR_APERTURE, reg_data_t'(ap));
    write_reg(ADDR_CLK_FIX, reg_data_t'(fix));
    write_reg(ADDR_CLK_VAR, reg_data_t'(var_c));
  endtask

  task automatic arm_once();
    arm_i = 1'b1;
    step();
    arm_i = 1'b0;
  endtask

  function automatic seq_entry_t entry_of(input int i);
    seq_entry_t e;
    e.azmux = azmux_t'(3 * i + 2);
    e.pc_sw = pc_sw_t'(3 - i);
    return e;
  endfunction

  // one conversion of the integrator model from zero
  function automatic adc_result_t balance_model(input int sig, input int ap, input int fix,
                                                input int var_c);
    adc_result_t r;
    int          acc;
    int          c;
    logic        cmp;
    r   = '0;
    acc = 0;
    for (c = 0; c < ap; c++) begin
      cmp = (acc > 0);              // comparator at the first clock of the cycle
      if (cmp) begin
        r.count_pos = r.count_pos + cycle_count_t'(1);
        acc = acc - var_c * REF_WEIGHT;
      end else begin
        r.count_neg = r.count_neg + cycle_count_t'(1);
        acc = acc + var_c * REF_WEIGHT;
      end
      acc = acc + (fix + var_c) * sig;  // signal on through both phases
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_pins(input string what, input pin_bus_t exp, input pin_bus_t act);
    if (act !== exp) begin
      $display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_result(input string what, input adc_result_t exp,
                              input adc_result_t act);
    if (act !== exp) begin
      $display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_entry(input string what, input seq_entry_t exp, input seq_entry_t act);
    if (act !== exp) begin
      $display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_index(input string what, input seq_idx_t exp, input seq_idx_t act);
    if (act !== exp) begin
      $display("** Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_clocks(input string what, input clk_count_t exp, input clk_count_t act);
    if (act !== exp) begin
      $display("** Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_cycles(input string what, input cycle_count_t exp,
                              input cycle_count_t act);
    if (act !== exp) begin
      $display("** Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic end_test(input int e0);
    if (err_cnt == e0) begin
      pass_cnt++;
      $display("%s: pass", cur_test);
    end else begin
      fail_cnt++;
      $display("%s: FAIL, %0d errors", cur_test, err_cnt - e0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests

  task automatic test_reset();
    int e0;
    int i;
    e0 = err_cnt;
    cur_test = "reset";
    for (i = 0; i < RESET_WATCH; i++) begin
      check_pins("idle pins", '0, pins_seen);  // MODE_LO with meas_complete included
      step();
    end
    end_test(e0);
  endtask

  task automatic test_direct();
    int       e0;
    int       i;
    pin_bus_t prev;
    pin_bus_t exp_p;
    e0 = err_cnt;
    cur_test = "direct";
    write_reg(ADDR_MODE, reg_data_t'(MODE_DIRECT));
    step();
    prev = '0;                                // direct register still at reset
    check_pins("switch to direct", prev, pins_seen);
    for (i = 0; i < DIRECT_N; i++) begin
      rng   = xorshift(rng);
      exp_p = pin_bus_t'(rng[23:0]);          // top byte dropped by the bank
      write_reg(ADDR_DIRECT, rng);
      check_pins("before pin register", prev, pins_seen);
      step();
      check_pins("after pin register", exp_p, pins_seen);
      prev = exp_p;
    end
    end_test(e0);
  endtask

  task automatic test_latency();
    int   e0;
    int   n;
    int   first_sig;
    int   last_sig;
    int   sig_n;
    int   faults;
    int   refs;
    int   latch_bad;
    logic in_conv;
    logic seen;
    e0 = err_cnt;
    cur_test = "latency";
    setup_conv(LAT_PC, 0, LAT_AP, LAT_FIX, LAT_VAR);
    write_reg(ADDR_SEQ0, reg_data_t'(LAT_ENTRY));
    write_reg(ADDR_MODE, reg_data_t'(MODE_ACQ));
    integ = 0;
    arm_once();
    while (azmux_o !== LAT_ENTRY.azmux) step();  // first clock of the entry on the pins
    check_entry("entry switches", LAT_ENTRY, seq_entry_t'({azmux_o, pc_sw_o}));
    n         = 0;
    first_sig = 0;
    last_sig  = 0;
    sig_n     = 0;
    faults    = 0;
    latch_bad = 0;
    seen      = 1'b0;
    while (meas_complete_o !== 1'b1) begin
      // converter runs from the precharge end for aperture*(fix+var) clocks
      in_conv = (n >= LAT_PC + 2) && (n < LAT_PC + 2 + LAT_AP * (LAT_FIX + LAT_VAR));
      if (adc_cmpr_latch_ctl_o !== !in_conv) latch_bad++;
      if (adc_refmux_o[REFMUX_SIG]) begin
        if (!seen) first_sig = n;
        seen     = 1'b1;
        last_sig = n;
        sig_n++;
        refs = int'(adc_refmux_o[REFMUX_POS]) + int'(adc_refmux_o[REFMUX_NEG])
             + int'(adc_refmux_o[REFMUX_RESET]);
        if (refs != 1) faults++;          // one reference switch per clock
      end
      step();
      n++;
    end
    // precharge+1, then aperture*(fix+var)+1 to done, then meas and pin flops
    check_clocks("entry to complete",
                 clk_count_t'(LAT_PC + 3 + LAT_AP * (LAT_FIX + LAT_VAR)), clk_count_t'(n));
    check_clocks("entry to signal on", clk_count_t'(LAT_PC + 2), clk_count_t'(first_sig));
    check_clocks("signal on clocks",
                 clk_count_t'(LAT_AP * (LAT_FIX + LAT_VAR)), clk_count_t'(sig_n));
    check_clocks("signal on span", clk_count_t'(LAT_AP * (LAT_FIX + LAT_VAR)),
                 clk_count_t'(last_sig - first_sig + 1));
    check_clocks("clocks without one reference", '0, clk_count_t'(faults));
    check_clocks("clocks with a wrong comparator latch", '0, clk_count_t'(latch_bad));
    repeat (4) step();
    end_test(e0);
  endtask

  task automatic test_balance();
    int          e0;
    int          run;
    adc_result_t exp_r;
    e0 = err_cnt;
    cur_test = "balance";
    setup_conv(BAL_PC, 0, BAL_AP, BAL_FIX, BAL_VAR);
    for (run = 0; run < BAL_RUNS; run++) begin
      rng   = xorshift(rng);
      sig_w = int'(rng % 32'd801) - 400;  // below what one reference phase can cancel
      integ = 0;
      adc_cmpr_p_i = 1'b0;
      exp_r = balance_model(sig_w, BAL_AP, BAL_FIX, BAL_VAR);
      arm_once();
      while (meas_complete_o !== 1'b1) step();
      check_result("counts", exp_r, result_o);
      check_cycles("pos plus neg", cycle_count_t'(BAL_AP),
                   result_o.count_pos + result_o.count_neg);
      repeat (3) step();
    end
    sig_w = 0;
    end_test(e0);
  endtask

  task automatic test_sequence();
    int e0;
    int i;
    int k;
    int extra;
    e0 = err_cnt;
    cur_test = "sequence";
    setup_conv(SEQ_PC, SEQ_MAX - 1, SEQ_AP, SEQ_FIX, SEQ_VAR);
    for (i = 0; i < SEQ_MAX; i++) begin
      write_reg(reg_addr_t'(int'(ADDR_SEQ0) + i), reg_data_t'(entry_of(i)));
    end
    integ = 0;
    arm_i = 1'b1;                         // held so entries run back to back
    for (k = 0; k < SEQ_SAMPLES; k++) begin
      while (meas_complete_o !== 1'b1) step();
      check_index("entry index", seq_idx_t'(k % SEQ_MAX), result_o.seq_idx);
      // switches of the finished entry are still on the pins
      check_entry("entry switches", entry_of(k % SEQ_MAX), seq_entry_t'({azmux_o, pc_sw_o}));
      if (k == SEQ_SAMPLES - 1) arm_i = 1'b0;
      step();
    end
    extra = 0;
    repeat (SEQ_WIN) begin
      if (meas_complete_o === 1'b1) begin
        extra++;
        check_index("last entry index", seq_idx_t'(SEQ_SAMPLES % SEQ_MAX), result_o.seq_idx);
      end
      step();
    end
    check_clocks("completions after disarm", clk_count_t'(1), clk_count_t'(extra));
    end_test(e0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main

  initial begin
    rst_n_i      = 1'b0;
    reg_wr_i     = 1'b0;
    reg_addr_i   = '0;
    reg_data_i   = '0;
    arm_i        = 1'b0;
    adc_cmpr_p_i = 1'b0;
    rng          = 32'h6a04;
    integ        = 0;
    sig_w        = 0;
    err_cnt      = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    cur_test     = "";
    repeat (RESET_CLKS) step();
    rst_n_i = 1'b1;
    step();
    test_reset();
    test_direct();
    test_latency();
    test_balance();
    test_sequence();
    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sim.f
dmm_pkg.sv
dmm_regs.sv
seq_ctrl.sv
adc_modulation.sv
pin_mux.sv
dmm_top.sv
tb_dmm_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only if the pass line is printed
set -u
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_dmm_top -o tb_dmm_top
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/tb_dmm_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1
